//--- hw/seq_pkg.sv
// ==============================
// Sequence tracker shared types
// Lane count, field widths and
// the payload and lane structs
// ==============================

`default_nettype none

package seq_pkg;

  // Number of lanes that can be granted or retired in one cycle
  localparam int LANES = 2;

  // Width of a sequence number, enough for up to 16 entries
  localparam int ENTRY_ID_W = 4;

  // Width of an entry count, holds 0 to 16
  localparam int COUNT_W = 5;

  // Width of a per-cycle lane count, holds 0 to LANES
  localparam int LANE_COUNT_W = 2;

  typedef logic [ENTRY_ID_W-1:0] entry_id_t;
  typedef logic [COUNT_W-1:0] entry_count_t;
  typedef logic [LANE_COUNT_W-1:0] lane_count_t;

  // Payload carried by one request lane
  typedef struct packed {
    logic [3:0]  opcode;
    logic [15:0] data;
  } payload_t;

  // A granted payload tagged with the sequence number it was given
  typedef struct packed {
    entry_id_t id;
    payload_t  payload;
  } issue_lane_t;

endpackage

`default_nettype wire

//--- hw/seq_counter_incr.sv
// ==============================
// Wrapping increment counter
// Adds up to LANES per cycle and
// wraps modulo NumEntries
// ==============================

`timescale 1ns/100ps
`default_nettype none

module seq_counter_incr #(
  parameter int NumEntries = 12
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                incr_valid,
  input  seq_pkg::lane_count_t incr,
  output seq_pkg::entry_id_t   value
);

  // The sum is held one bit wider than an id so that value plus incr
  // can never overflow before the wrap is applied
  seq_pkg::entry_count_t sum;
  seq_pkg::entry_count_t sum_wrapped;
  seq_pkg::entry_id_t    value_next;

  assign sum = seq_pkg::entry_count_t'(value) + seq_pkg::entry_count_t'(incr);

  // An increment is at most 2 and NumEntries is at least 2, so one
  // subtraction always brings the sum back into range
  assign sum_wrapped = (sum >= seq_pkg::entry_count_t'(NumEntries)) ?
                       (sum - seq_pkg::entry_count_t'(NumEntries)) : sum;

  // Hold the current value on cycles without an increment
  assign value_next = incr_valid ? seq_pkg::entry_id_t'(sum_wrapped) : value;

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else begin
      value <= value_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/seq_counter_updown.sv
// ==============================
// Up/down entry counter
// Adds and subtracts lane counts
// in the same cycle
// ==============================

`timescale 1ns/100ps
`default_nettype none

module seq_counter_updown #(
  parameter int NumEntries = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  incr_valid,
  input  seq_pkg::lane_count_t   incr,
  input  logic                  decr_valid,
  input  seq_pkg::lane_count_t   decr,
  output seq_pkg::entry_count_t  value
);

  seq_pkg::entry_count_t incr_amount;
  seq_pkg::entry_count_t decr_amount;
  seq_pkg::entry_count_t value_next;

  // A side that is not valid contributes nothing
  assign incr_amount = incr_valid ? seq_pkg::entry_count_t'(incr) : '0;
  assign decr_amount = decr_valid ? seq_pkg::entry_count_t'(decr) : '0;

  // Both changes land together; legal traffic keeps the result
  // between 0 and NumEntries, so no wrap or clamp is applied
  assign value_next = value + incr_amount - decr_amount;

  always_ff @(posedge clk) begin
    if (rst) begin
      // The counter starts full, every entry is free
      value <= seq_pkg::entry_count_t'(NumEntries);
    end else begin
      value <= value_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/seq_tracker.sv
// ==============================
// Sequence number tracker
// Hands out in-order ids per lane
// and tracks free and used counts
// ==============================

`timescale 1ns/100ps
`default_nettype none

module seq_tracker #(
  parameter int NumEntries = 12
) (
  input  logic                                           clk,
  input  logic                                           rst,

  // Allocation side, the grant is min(receivable, sendable)
  input  seq_pkg::lane_count_t                           alloc_receivable,
  output seq_pkg::lane_count_t                           alloc_sendable,
  output seq_pkg::entry_id_t [seq_pkg::LANES-1:0]        alloc_entry_id,

  // Deallocation side, only a count because frees are in order
  input  logic                                           dealloc_valid,
  input  seq_pkg::lane_count_t                           dealloc_size,

  output seq_pkg::entry_count_t                          free_entry_count,
  output seq_pkg::entry_count_t                          allocated_entry_count
);

  logic                 alloc_beat;
  seq_pkg::lane_count_t alloc_size;

  // Number of lanes actually taken this cycle
  assign alloc_size = (alloc_receivable > alloc_sendable) ? alloc_sendable
                                                          : alloc_receivable;
  assign alloc_beat = (alloc_size != '0);

  // The next id to hand out, advanced by the grant on each edge
  seq_counter_incr #(
    .NumEntries(NumEntries)
  ) u_alloc_counter (
    .clk       (clk),
    .rst       (rst),
    .incr_valid(alloc_beat),
    .incr      (alloc_size),
    .value     (alloc_entry_id[0])
  );

  // Each further lane takes the id after the previous one, wrapped
  for (genvar i = 1; i < seq_pkg::LANES; i++) begin : gen_lane_id
    seq_pkg::entry_count_t next_id;
    seq_pkg::entry_count_t next_id_wrapped;

    assign next_id = seq_pkg::entry_count_t'(alloc_entry_id[0]) +
                     seq_pkg::entry_count_t'(i);
    assign next_id_wrapped = (next_id >= seq_pkg::entry_count_t'(NumEntries)) ?
                             (next_id - seq_pkg::entry_count_t'(NumEntries)) : next_id;
    assign alloc_entry_id[i] = seq_pkg::entry_id_t'(next_id_wrapped);
  end

  // Free entries go up on a dealloc and down on a grant
  seq_counter_updown #(
    .NumEntries(NumEntries)
  ) u_free_counter (
    .clk       (clk),
    .rst       (rst),
    .incr_valid(dealloc_valid),
    .incr      (dealloc_size),
    .decr_valid(alloc_beat),
    .decr      (alloc_size),
    .value     (free_entry_count)
  );

  assign allocated_entry_count = seq_pkg::entry_count_t'(NumEntries) - free_entry_count;

  // At most LANES ids can go out per cycle, fewer when nearly full
  assign alloc_sendable =
    (free_entry_count > seq_pkg::entry_count_t'(seq_pkg::LANES)) ?
    seq_pkg::lane_count_t'(seq_pkg::LANES) : seq_pkg::lane_count_t'(free_entry_count);

endmodule

`default_nettype wire

//--- hw/entry_store.sv
// ==============================
// Entry payload store
// Two write lanes by id and two
// asynchronous read lanes
// ==============================

`timescale 1ns/100ps
`default_nettype none

module entry_store #(
  parameter int NumEntries = 12
) (
  input  logic                                        clk,

  // Write side, lanes 0 up to wr_count minus 1 are written
  input  seq_pkg::lane_count_t                        wr_count,
  input  seq_pkg::issue_lane_t [seq_pkg::LANES-1:0]   wr_lane,

  // Read side, combinational from id to payload
  input  seq_pkg::entry_id_t [seq_pkg::LANES-1:0]     rd_id,
  output seq_pkg::payload_t [seq_pkg::LANES-1:0]      rd_payload
);

  // One payload per sequence number
  seq_pkg::payload_t mem [NumEntries];

  // Granted lanes always carry distinct ids, so the lanes never
  // collide on the same entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < seq_pkg::LANES; i++) begin
      if (seq_pkg::lane_count_t'(i) < wr_count) begin
        mem[wr_lane[i].id] <= wr_lane[i].payload;
      end
    end
  end

  // An entry is only read once it has been issued and completed,
  // so the memory needs no initial contents
  always_comb begin
    for (int i = 0; i < seq_pkg::LANES; i++) begin
      rd_payload[i] = mem[rd_id[i]];
    end
  end

endmodule

`default_nettype wire

//--- hw/retire_unit.sv
// ==============================
// In-order retire unit
// Counts completions and returns
// the oldest payloads, freeing ids
// ==============================

`timescale 1ns/100ps
`default_nettype none

module retire_unit #(
  parameter int NumEntries = 12
) (
  input  logic                                      clk,
  input  logic                                      rst,

  // Completions arrive in issue order, so only a count is given
  input  logic                                      cmpl_valid,
  input  seq_pkg::lane_count_t                      cmpl_size,

  // Store read port
  output seq_pkg::entry_id_t [seq_pkg::LANES-1:0]   rd_id,
  input  seq_pkg::payload_t [seq_pkg::LANES-1:0]    rd_payload,

  // Consumer side, retired count is min(sendable, receivable)
  input  seq_pkg::lane_count_t                      retire_receivable,
  output seq_pkg::lane_count_t                      retire_sendable,
  output seq_pkg::payload_t [seq_pkg::LANES-1:0]    retire_lane,

  // Entries released back to the tracker
  output logic                                      dealloc_valid,
  output seq_pkg::lane_count_t                      dealloc_size
);

  seq_pkg::entry_count_t pending;
  seq_pkg::entry_count_t cmpl_amount;
  seq_pkg::entry_id_t    head;
  seq_pkg::entry_count_t head_sum;
  seq_pkg::lane_count_t  retired;

  // Completed entries are offered at most LANES at a time
  assign retire_sendable =
    (pending > seq_pkg::entry_count_t'(seq_pkg::LANES)) ?
    seq_pkg::lane_count_t'(seq_pkg::LANES) : seq_pkg::lane_count_t'(pending);

  assign retired = (retire_receivable > retire_sendable) ? retire_sendable
                                                         : retire_receivable;

  assign cmpl_amount = cmpl_valid ? seq_pkg::entry_count_t'(cmpl_size) : '0;

  // Oldest entry first, the next lane reads the one after it
  for (genvar i = 0; i < seq_pkg::LANES; i++) begin : gen_rd_id
    seq_pkg::entry_count_t id_sum;

    assign id_sum = seq_pkg::entry_count_t'(head) + seq_pkg::entry_count_t'(i);
    assign rd_id[i] = (id_sum >= seq_pkg::entry_count_t'(NumEntries)) ?
                      seq_pkg::entry_id_t'(id_sum - seq_pkg::entry_count_t'(NumEntries)) :
                      seq_pkg::entry_id_t'(id_sum);
  end

  // Store data goes straight out; only the first retired lanes are valid
  assign retire_lane = rd_payload;

  assign dealloc_valid = (retired != '0);
  assign dealloc_size  = retired;

  // Head moves past every retired entry, wrapping at NumEntries
  assign head_sum = seq_pkg::entry_count_t'(head) + seq_pkg::entry_count_t'(retired);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      head    <= '0;
    end else begin
      pending <= pending + cmpl_amount - seq_pkg::entry_count_t'(retired);
      if (head_sum >= seq_pkg::entry_count_t'(NumEntries)) begin
        head <= seq_pkg::entry_id_t'(head_sum - seq_pkg::entry_count_t'(NumEntries));
      end else begin
        head <= seq_pkg::entry_id_t'(head_sum);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/seq_track_top.sv
// ==============================
// Request tracker top level
// Tracker, payload store and the
// in-order retire stage
// ==============================

`timescale 1ns/100ps
`default_nettype none

module seq_track_top #(
  parameter int NumEntries = 12
) (
  input  logic                                        clk,
  input  logic                                        rst,

  // Requester side
  input  seq_pkg::lane_count_t                        req_receivable,
  input  seq_pkg::payload_t [seq_pkg::LANES-1:0]      req_payload,
  output seq_pkg::lane_count_t                        req_sendable,
  output seq_pkg::issue_lane_t [seq_pkg::LANES-1:0]   issue_lane,

  // Completion side
  input  logic                                        cmpl_valid,
  input  seq_pkg::lane_count_t                        cmpl_size,

  // Retire side
  input  seq_pkg::lane_count_t                        retire_receivable,
  output seq_pkg::lane_count_t                        retire_sendable,
  output seq_pkg::payload_t [seq_pkg::LANES-1:0]      retire_lane,

  output seq_pkg::entry_count_t                       free_count,
  output seq_pkg::entry_count_t                       allocated_count
);

  seq_pkg::lane_count_t                       grant;
  seq_pkg::entry_id_t [seq_pkg::LANES-1:0]    alloc_id;
  seq_pkg::entry_id_t [seq_pkg::LANES-1:0]    rd_id;
  seq_pkg::payload_t [seq_pkg::LANES-1:0]     rd_payload;
  logic                                       dealloc_valid;
  seq_pkg::lane_count_t                       dealloc_size;

  seq_tracker #(
    .NumEntries(NumEntries)
  ) u_tracker (
    .clk                  (clk),
    .rst                  (rst),
    .alloc_receivable     (req_receivable),
    .alloc_sendable       (req_sendable),
    .alloc_entry_id       (alloc_id),
    .dealloc_valid        (dealloc_valid),
    .dealloc_size         (dealloc_size),
    .free_entry_count     (free_count),
    .allocated_entry_count(allocated_count)
  );

  // Same grant the tracker applies, built from its sendable count
  assign grant = (req_receivable > req_sendable) ? req_sendable : req_receivable;

  // Tag each request lane with the id it is given this cycle
  for (genvar i = 0; i < seq_pkg::LANES; i++) begin : gen_issue
    assign issue_lane[i].id      = alloc_id[i];
    assign issue_lane[i].payload = req_payload[i];
  end

  entry_store #(
    .NumEntries(NumEntries)
  ) u_store (
    .clk       (clk),
    .wr_count  (grant),
    .wr_lane   (issue_lane),
    .rd_id     (rd_id),
    .rd_payload(rd_payload)
  );

  retire_unit #(
    .NumEntries(NumEntries)
  ) u_retire (
    .clk              (clk),
    .rst              (rst),
    .cmpl_valid       (cmpl_valid),
    .cmpl_size        (cmpl_size),
    .rd_id            (rd_id),
    .rd_payload       (rd_payload),
    .retire_receivable(retire_receivable),
    .retire_sendable  (retire_sendable),
    .retire_lane      (retire_lane),
    .dealloc_valid    (dealloc_valid),
    .dealloc_size     (dealloc_size)
  );

endmodule

`default_nettype wire

//--- sim/tb_seq_track_top.sv
// ==============================
// Request tracker testbench
// Directed tests with an in-order
// scoreboard of issued payloads
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_seq_track_top;

  localparam int NUM_ENTRIES   = 12;
  localparam int CLK_PERIOD    = 20;
  localparam int DRAIN_LIMIT   = 40;
  // Reset, the five tests and one drain after each of four tests
  localparam int TEST_CYCLES   = 10 + 1 + 10 + 12 + 10 + 200 + 4 * DRAIN_LIMIT;
  localparam int MARGIN_CYCLES = 100;

  logic                                      clk = 1'b0;
  logic                                      rst;
  seq_pkg::lane_count_t                      req_receivable;
  seq_pkg::payload_t [seq_pkg::LANES-1:0]    req_payload;
  seq_pkg::lane_count_t                      req_sendable;
  seq_pkg::issue_lane_t [seq_pkg::LANES-1:0] issue_lane;
  logic                                      cmpl_valid;
  seq_pkg::lane_count_t                      cmpl_size;
  seq_pkg::lane_count_t                      retire_receivable;
  seq_pkg::lane_count_t                      retire_sendable;
  seq_pkg::payload_t [seq_pkg::LANES-1:0]    retire_lane;
  seq_pkg::entry_count_t                     free_count;
  seq_pkg::entry_count_t                     allocated_count;

  // Scoreboard state, all of it describes the DUT after the next edge
  seq_pkg::payload_t issue_q [$];
  int     next_id      = 0;
  int     model_free   = NUM_ENTRIES;
  int     pending      = 0;
  int     outstanding  = 0;
  int     tag          = 0;
  int     mismatch_count = 0;
  int     other_count  = 0;
  integer seed         = 32'h5c0a_91aa;
  string  test_name    = "none";

  seq_track_top #(
    .NumEntries(NUM_ENTRIES)
  ) DUT (
    .clk              (clk),
    .rst              (rst),
    .req_receivable   (req_receivable),
    .req_payload      (req_payload),
    .req_sendable     (req_sendable),
    .issue_lane       (issue_lane),
    .cmpl_valid       (cmpl_valid),
    .cmpl_size        (cmpl_size),
    .retire_receivable(retire_receivable),
    .retire_sendable  (retire_sendable),
    .retire_lane      (retire_lane),
    .free_count       (free_count),
    .allocated_count  (allocated_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int smaller_of(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // Opcode follows a running tag so neighbouring payloads differ
  function automatic seq_pkg::payload_t make_payload();
    seq_pkg::payload_t p;
    p.opcode = tag[3:0];
    p.data   = 16'($random(seed));
    tag      = tag + 1;
    return p;
  endfunction

  task automatic check_id(input string what, input seq_pkg::entry_id_t exp,
                          input seq_pkg::entry_id_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: %s expected %0d, got %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input seq_pkg::entry_count_t exp,
                             input seq_pkg::entry_count_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: %s expected %0d, got %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_lanes(input string what, input seq_pkg::lane_count_t exp,
                             input seq_pkg::lane_count_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: %s expected %0d, got %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_payload(input string what, input seq_pkg::payload_t exp,
                               input seq_pkg::payload_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: %s expected %h, got %h", test_name, what, exp, act);
    end
  endtask

  // One clock cycle: drive on the rising edge, check at the falling edge,
  // then move the model on to what the next rising edge will do
  task automatic run_cycle(input int offer, input int cmpl, input int recv);
    seq_pkg::payload_t lanes [seq_pkg::LANES];
    int exp_send;
    int grant;
    int exp_rs;
    int retired;
    for (int i = 0; i < seq_pkg::LANES; i++) begin
      lanes[i] = make_payload();
    end
    @(posedge clk);
    req_receivable <= seq_pkg::lane_count_t'(offer);
    for (int i = 0; i < seq_pkg::LANES; i++) begin
      req_payload[i] <= lanes[i];
    end
    cmpl_valid        <= (cmpl != 0);
    cmpl_size         <= seq_pkg::lane_count_t'(cmpl);
    retire_receivable <= seq_pkg::lane_count_t'(recv);
    @(negedge clk);
    exp_send = smaller_of(seq_pkg::LANES, model_free);
    grant    = smaller_of(offer, exp_send);
    exp_rs   = smaller_of(pending, seq_pkg::LANES);
    retired  = smaller_of(exp_rs, recv);
    check_lanes("req_sendable", seq_pkg::lane_count_t'(exp_send), req_sendable);
    check_lanes("retire_sendable", seq_pkg::lane_count_t'(exp_rs), retire_sendable);
    check_count("free_count", seq_pkg::entry_count_t'(model_free), free_count);
    // Every entry that is not free is allocated
    check_count("allocated_count", seq_pkg::entry_count_t'(NUM_ENTRIES - model_free),
                allocated_count);
    for (int i = 0; i < grant; i++) begin
      check_id("issue id", seq_pkg::entry_id_t'((next_id + i) % NUM_ENTRIES),
               issue_lane[i].id);
      check_payload("issue payload", lanes[i], issue_lane[i].payload);
    end
    // Valid retire lanes show the oldest completed payloads
    for (int i = 0; i < exp_rs; i++) begin
      check_payload("retire payload", issue_q[i], retire_lane[i]);
    end
    for (int i = 0; i < grant; i++) begin
      issue_q.push_back(lanes[i]);
    end
    repeat (retired) void'(issue_q.pop_front());
    next_id     = (next_id + grant) % NUM_ENTRIES;
    model_free  = model_free - grant + retired;
    pending     = pending + cmpl - retired;
    outstanding = outstanding + grant - cmpl;
  endtask

  // Complete and retire everything still in flight
  task automatic drain_all();
    int cycles = 0;
    while (issue_q.size() > 0 && cycles < DRAIN_LIMIT) begin
      run_cycle(0, smaller_of(outstanding, seq_pkg::LANES), seq_pkg::LANES);
      cycles++;
    end
    if (issue_q.size() > 0) begin
      other_count++;
      $display("Drain in %s left %0d entries in flight after %0d cycles",
               test_name, issue_q.size(), DRAIN_LIMIT);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk);
    check_count("free_count", 5'd12, free_count);
    check_count("allocated_count", 5'd0, allocated_count);
    check_lanes("req_sendable", 2'd2, req_sendable);
    check_lanes("retire_sendable", 2'd0, retire_sendable);
  endtask

  // Offers of 2 and 1 in turn; 15 ids pass the wrap at 12
  task automatic test_wrap();
    test_name = "wrap";
    for (int i = 0; i < 10; i++) begin
      run_cycle((i % 2 == 0) ? 2 : 1, smaller_of(outstanding, 2), 2);
    end
    drain_all();
  endtask

  task automatic test_fill();
    test_name = "fill";
    repeat (5) run_cycle(2, 0, 0);
    run_cycle(1, 0, 0);
    run_cycle(0, 0, 0);
    check_lanes("req_sendable at 11", 2'd1, req_sendable);
    check_count("allocated at 11", 5'd11, allocated_count);
    // Only one of the two offered lanes fits
    run_cycle(2, 0, 0);
    run_cycle(0, 0, 0);
    check_lanes("req_sendable when full", 2'd0, req_sendable);
    check_count("allocated when full", 5'd12, allocated_count);
    run_cycle(0, 2, 0);
    run_cycle(0, 0, 2);
    run_cycle(0, 0, 0);
    check_lanes("req_sendable after retire", 2'd2, req_sendable);
    drain_all();
  endtask

  task automatic test_retire();
    test_name = "retire";
    run_cycle(2, 0, 0);
    run_cycle(1, 0, 0);
    run_cycle(0, 2, 0);
    run_cycle(0, 1, 0);
    // Consumer stalls, the same two payloads must stay on the lanes
    repeat (3) run_cycle(0, 0, 0);
    check_lanes("retire_sendable held", 2'd2, retire_sendable);
    run_cycle(0, 0, 1);
    run_cycle(0, 0, 2);
    run_cycle(0, 0, 0);
    check_lanes("retire_sendable drained", 2'd0, retire_sendable);
    drain_all();
  endtask

  task automatic test_random();
    int offer;
    int cmpl;
    int recv;
    test_name = "random";
    for (int i = 0; i < 200; i++) begin
      offer = {$random(seed)} % 3;
      cmpl  = 0;
      if (outstanding > 0) begin
        cmpl = {$random(seed)} % (smaller_of(outstanding, 2) + 1);
      end
      recv = {$random(seed)} % 3;
      run_cycle(offer, cmpl, recv);
    end
    drain_all();
  endtask

  initial begin
    rst               = 1'b1;
    req_receivable    = '0;
    req_payload       = '0;
    cmpl_valid        = 1'b0;
    cmpl_size         = '0;
    retire_receivable = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_wrap();
    test_fill();
    test_retire();
    test_random();
    $display("Error summary: %0d mismatches, %0d other failures",
             mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Stops a run that hangs past the expected test length
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    $display("Timeout in %s: the tests did not finish in the expected time", test_name);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hw/seq_pkg.sv
hw/seq_counter_incr.sv
hw/seq_counter_updown.sv
hw/seq_tracker.sv
hw/entry_store.sv
hw/retire_unit.sv
hw/seq_track_top.sv
sim/tb_seq_track_top.sv
